// File: Bender.yml
package:
  name: l2c_slice

sources:
  - l2c_pkg.sv
  - l2c_acc_timer.sv
  - l2c_req_queue.sv
  - l2c_flush_ctrl.sv
  - l2c_bank.sv
  - l2c_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_l2c_top.sv

// File: compile.f
l2c_pkg.sv
l2c_acc_timer.sv
l2c_req_queue.sv
l2c_flush_ctrl.sv
l2c_bank.sv
l2c_top.sv
tb_clk_gen.sv
tb_l2c_top.sv

// File: l2c_acc_timer.sv
//====================================================================
// Access timer
// Clamps the tag and data access cycles and times one access
//====================================================================

module l2c_acc_timer import l2c_pkg::*; (
  input  logic       forever_cpuclk,
  input  logic       cpurst_b,
  input  logic       start,
  input  logic       tag_setup,
  input  logic [2:0] tag_latency,
  input  logic       data_setup,
  input  logic [2:0] data_latency,
  output logic       busy,
  output logic       done
);

  logic [L2C_CYC_W-1:0] tag_sum;
  logic [L2C_CYC_W-1:0] data_sum;
  logic [L2C_CYC_W-1:0] tag_cyc;
  logic [L2C_CYC_W-1:0] data_cyc;
  logic [L2C_CYC_W-1:0] acc_cyc;
  logic [L2C_CYC_W-1:0] acc_load;
  logic [L2C_CYC_W-1:0] cnt;

  assign tag_sum  = L2C_CYC_W'(tag_setup) + L2C_CYC_W'(tag_latency);
  assign data_sum = L2C_CYC_W'(data_setup) + L2C_CYC_W'(data_latency);

  assign tag_cyc  = (tag_sum > L2C_CYC_W'(L2C_TAG_CYC_MAX)) ?
                    L2C_CYC_W'(L2C_TAG_CYC_MAX) : tag_sum;
  assign data_cyc = (data_sum > L2C_CYC_W'(L2C_DATA_CYC_MAX)) ?
                    L2C_CYC_W'(L2C_DATA_CYC_MAX) : data_sum;

  // An access takes at least one cycle
  assign acc_cyc  = tag_cyc + data_cyc;
  assign acc_load = (acc_cyc == '0) ? L2C_CYC_W'(1) : acc_cyc;

  // Done fires on the edge where the count leaves 1
  always_ff @(posedge forever_cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        cnt <= acc_load;
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == L2C_CYC_W'(1)) begin
          done <= 1'b1;
        end
      end
    end
  end

  assign busy = (cnt != '0);

endmodule

// File: l2c_bank.sv
//====================================================================
// L2 cache bank
// Direct-mapped line store with timed lookup, write fill and a
// flush walk over the valid bits
//====================================================================

module l2c_bank import l2c_pkg::*; (
  input  logic                  forever_cpuclk,
  input  logic                  cpurst_b,
  input  logic                  req_vld,
  input  l2c_op_e               req_op,
  input  logic [L2C_ADDR_W-1:0] req_addr,
  input  logic [L2C_DATA_W-1:0] req_wdata,
  input  logic                  tag_setup,
  input  logic [2:0]            tag_latency,
  input  logic                  data_setup,
  input  logic [2:0]            data_latency,
  input  logic                  bank_flush_req,
  output logic                  credit_ret,
  output logic                  cmplt,
  output l2c_resp_e             resp,
  output logic [L2C_DATA_W-1:0] rdata,
  output logic                  bank_flush_done,
  output logic                  bank_idle
);

  logic                   head_vld;
  l2c_op_e                head_op;
  logic [L2C_ADDR_W-1:0]  head_addr;
  logic [L2C_DATA_W-1:0]  head_wdata;
  logic                   pop;
  logic                   acc_busy;
  logic                   acc_done;

  l2c_op_e                cur_op;
  logic [L2C_ADDR_W-1:0]  cur_addr;
  logic [L2C_DATA_W-1:0]  cur_wdata;
  logic [L2C_INDEX_W-1:0] cur_idx;
  logic [L2C_TAG_W-1:0]   cur_tag;
  logic                   line_hit;

  logic [L2C_SETS-1:0]    valid_q;
  logic [L2C_TAG_W-1:0]   tag_mem  [L2C_SETS];
  logic [L2C_DATA_W-1:0]  data_mem [L2C_SETS];

  logic                   flush_start;
  logic                   flush_active;
  logic                   flush_held;
  logic [L2C_INDEX_W-1:0] walk_idx;

  l2c_req_queue i_req_queue (
    .forever_cpuclk (forever_cpuclk),
    .cpurst_b       (cpurst_b),
    .push           (req_vld),
    .push_op        (req_op),
    .push_addr      (req_addr),
    .push_wdata     (req_wdata),
    .pop            (pop),
    .head_vld       (head_vld),
    .head_op        (head_op),
    .head_addr      (head_addr),
    .head_wdata     (head_wdata),
    .credit_ret     (credit_ret)
  );

  // Next entry leaves the queue in the completion cycle of the last
  assign pop = head_vld & ~acc_busy & ~flush_active;

  l2c_acc_timer i_acc_timer (
    .forever_cpuclk (forever_cpuclk),
    .cpurst_b       (cpurst_b),
    .start          (pop),
    .tag_setup      (tag_setup),
    .tag_latency    (tag_latency),
    .data_setup     (data_setup),
    .data_latency   (data_latency),
    .busy           (acc_busy),
    .done           (acc_done)
  );

  always_ff @(posedge forever_cpuclk) begin
    if (pop) begin
      cur_op    <= head_op;
      cur_addr  <= head_addr;
      cur_wdata <= head_wdata;
    end
  end

  //====================================================================
  // Lookup and fill
  //====================================================================
  assign cur_idx  = cur_addr[L2C_INDEX_W-1:0];
  assign cur_tag  = cur_addr[L2C_ADDR_W-1:L2C_INDEX_W];
  assign line_hit = valid_q[cur_idx] && (tag_mem[cur_idx] == cur_tag);

  always_ff @(posedge forever_cpuclk) begin
    if (acc_done && (cur_op == L2C_OP_WRITE)) begin
      tag_mem[cur_idx]  <= cur_tag;
      data_mem[cur_idx] <= cur_wdata;
    end
  end

  // A flush never overlaps a fill since the walk needs an idle timer
  always_ff @(posedge forever_cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      valid_q <= '0;
    end else if (flush_active) begin
      valid_q[walk_idx] <= 1'b0;
    end else if (acc_done && (cur_op == L2C_OP_WRITE)) begin
      valid_q[cur_idx] <= 1'b1;
    end
  end

  assign cmplt = acc_done;

  always_comb begin
    resp = L2C_RESP_MISS;
    if (cur_op == L2C_OP_WRITE) begin
      resp = L2C_RESP_WACK;
    end else if (line_hit) begin
      resp = L2C_RESP_HIT;
    end
  end

  assign rdata = (acc_done && (cur_op == L2C_OP_READ) && line_hit) ?
                 data_mem[cur_idx] : '0;

  //====================================================================
  // Flush walk
  //====================================================================
  assign flush_start = bank_flush_req & ~flush_held & ~flush_active &
                       ~head_vld & ~acc_busy;

  always_ff @(posedge forever_cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      flush_active    <= 1'b0;
      flush_held      <= 1'b0;
      walk_idx        <= '0;
      bank_flush_done <= 1'b0;
    end else begin
      bank_flush_done <= 1'b0;
      if (flush_active) begin
        walk_idx <= walk_idx + 1'b1;
        if (walk_idx == L2C_INDEX_W'(L2C_SETS - 1)) begin
          flush_active    <= 1'b0;
          flush_held      <= 1'b1;
          bank_flush_done <= 1'b1;
        end
      end else if (flush_start) begin
        flush_active <= 1'b1;
        walk_idx     <= '0;
      end else if (!bank_flush_req) begin
        // Rearm once the request is withdrawn
        flush_held <= 1'b0;
      end
    end
  end

  assign bank_idle = ~head_vld & ~acc_busy & ~flush_active;

endmodule

// File: l2c_flush_ctrl.sv
//====================================================================
// SoC flush sequencer
// Requests a flush of both banks and collects their done pulses
//====================================================================

module l2c_flush_ctrl import l2c_pkg::*; (
  input  logic forever_cpuclk,
  input  logic cpurst_b,
  input  logic flush_req,
  input  logic ciu_no_op,
  input  logic bank_flush_done_0,
  input  logic bank_flush_done_1,
  output logic bank_flush_req,
  output logic flush_done,
  output logic flush_idle
);

  l2c_flush_state_e cur_state;
  l2c_flush_state_e next_state;

  always_comb begin
    next_state = cur_state;
    case (cur_state)
      FLUSH_IDLE: begin
        if (flush_req && ciu_no_op) begin
          next_state = FLUSH_REQ;
        end
      end
      // Banks may finish in either order
      FLUSH_REQ: begin
        if (bank_flush_done_0 && bank_flush_done_1) begin
          next_state = FLUSH_DONE;
        end else if (bank_flush_done_0) begin
          next_state = FLUSH_WAIT_1;
        end else if (bank_flush_done_1) begin
          next_state = FLUSH_WAIT_0;
        end
      end
      FLUSH_WAIT_1: begin
        if (bank_flush_done_1) begin
          next_state = FLUSH_DONE;
        end
      end
      FLUSH_WAIT_0: begin
        if (bank_flush_done_0) begin
          next_state = FLUSH_DONE;
        end
      end
      FLUSH_DONE: begin
        if (!flush_req) begin
          next_state = FLUSH_IDLE;
        end
      end
      default: next_state = FLUSH_IDLE;
    endcase
  end

  // Outputs are decoded from the next state so they track the state
  always_ff @(posedge forever_cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cur_state      <= FLUSH_IDLE;
      bank_flush_req <= 1'b0;
      flush_done     <= 1'b0;
      flush_idle     <= 1'b1;
    end else begin
      cur_state      <= next_state;
      bank_flush_req <= next_state inside {FLUSH_REQ, FLUSH_WAIT_1, FLUSH_WAIT_0};
      flush_done     <= (next_state == FLUSH_DONE);
      flush_idle     <= (next_state == FLUSH_IDLE);
    end
  end

endmodule

// File: l2c_pkg.sv
//====================================================================
// L2 cache slice shared definitions
// Sizes, access-cycle clamp limits and the opcode, response and
// flush state encodings
//====================================================================

package l2c_pkg;

  //====================================================================
  // Request and line geometry
  //====================================================================
  localparam int unsigned L2C_ADDR_W = 16;

  // Low address bits select the line and the rest form the tag
  localparam int unsigned L2C_INDEX_W = 4;
  localparam int unsigned L2C_TAG_W = L2C_ADDR_W - L2C_INDEX_W;
  localparam int unsigned L2C_SETS = 16;

  localparam int unsigned L2C_DATA_W = 64;

  // Queue depth per bank and the requester's starting credits
  localparam int unsigned L2C_REQ_CREDITS = 2;

  //====================================================================
  // Access timing
  //====================================================================
  // Setup plus latency is clamped to these counts
  localparam int unsigned L2C_TAG_CYC_MAX = 4;
  localparam int unsigned L2C_DATA_CYC_MAX = 8;

  // Wide enough for the summed tag and data cycles
  localparam int unsigned L2C_CYC_W = 4;

  //====================================================================
  // Encodings
  //====================================================================
  typedef enum logic [0:0] {
    L2C_OP_READ  = 1'b0,
    L2C_OP_WRITE = 1'b1
  } l2c_op_e;

  typedef enum logic [1:0] {
    L2C_RESP_HIT  = 2'b00,
    L2C_RESP_MISS = 2'b01,
    L2C_RESP_WACK = 2'b10
  } l2c_resp_e;

  // SoC flush sequencer
  typedef enum logic [2:0] {
    FLUSH_IDLE   = 3'b000,
    FLUSH_REQ    = 3'b001,
    FLUSH_WAIT_1 = 3'b010,
    FLUSH_WAIT_0 = 3'b011,
    FLUSH_DONE   = 3'b100
  } l2c_flush_state_e;

endpackage

// File: l2c_req_queue.sv
//====================================================================
// Bank request queue
// Two-entry FIFO that returns one credit per popped entry
//====================================================================

module l2c_req_queue import l2c_pkg::*; (
  input  logic                  forever_cpuclk,
  input  logic                  cpurst_b,
  input  logic                  push,
  input  l2c_op_e               push_op,
  input  logic [L2C_ADDR_W-1:0] push_addr,
  input  logic [L2C_DATA_W-1:0] push_wdata,
  input  logic                  pop,
  output logic                  head_vld,
  output l2c_op_e               head_op,
  output logic [L2C_ADDR_W-1:0] head_addr,
  output logic [L2C_DATA_W-1:0] head_wdata,
  output logic                  credit_ret
);

  logic [$clog2(L2C_REQ_CREDITS)-1:0]   wr_ptr;
  logic [$clog2(L2C_REQ_CREDITS)-1:0]   rd_ptr;
  logic [$clog2(L2C_REQ_CREDITS+1)-1:0] count;
  logic                                 do_pop;

  l2c_op_e               op_q    [L2C_REQ_CREDITS];
  logic [L2C_ADDR_W-1:0] addr_q  [L2C_REQ_CREDITS];
  logic [L2C_DATA_W-1:0] wdata_q [L2C_REQ_CREDITS];

  assign head_vld = (count != '0);
  assign do_pop   = pop & head_vld;

  //====================================================================
  // Pointers, fill level and credit return
  //====================================================================
  always_ff @(posedge forever_cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      credit_ret <= do_pop;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge forever_cpuclk) begin
    if (push) begin
      op_q[wr_ptr]    <= push_op;
      addr_q[wr_ptr]  <= push_addr;
      wdata_q[wr_ptr] <= push_wdata;
    end
  end

  assign head_op    = op_q[rd_ptr];
  assign head_addr  = addr_q[rd_ptr];
  assign head_wdata = wdata_q[rd_ptr];

endmodule

// File: l2c_top.sv
//====================================================================
// L2 cache slice top
// Two banks, the SoC flush sequencer and the quiescence output
//====================================================================

module l2c_top import l2c_pkg::*; (
  input  logic                  forever_cpuclk,
  input  logic                  cpurst_b,
  input  logic                  req_vld_bank_0,
  input  l2c_op_e               req_op_bank_0,
  input  logic [L2C_ADDR_W-1:0] req_addr_bank_0,
  input  logic [L2C_DATA_W-1:0] req_wdata_bank_0,
  input  logic                  req_vld_bank_1,
  input  l2c_op_e               req_op_bank_1,
  input  logic [L2C_ADDR_W-1:0] req_addr_bank_1,
  input  logic [L2C_DATA_W-1:0] req_wdata_bank_1,
  input  logic                  tag_setup,
  input  logic [2:0]            tag_latency,
  input  logic                  data_setup,
  input  logic [2:0]            data_latency,
  input  logic                  flush_req,
  input  logic                  ciu_no_op,
  output logic                  credit_ret_bank_0,
  output logic                  cmplt_bank_0,
  output l2c_resp_e             resp_bank_0,
  output logic [L2C_DATA_W-1:0] rdata_bank_0,
  output logic                  credit_ret_bank_1,
  output logic                  cmplt_bank_1,
  output l2c_resp_e             resp_bank_1,
  output logic [L2C_DATA_W-1:0] rdata_bank_1,
  output logic                  flush_done,
  output logic                  flush_idle,
  output logic                  no_op
);

  logic bank_flush_req;
  logic bank_flush_done_0;
  logic bank_flush_done_1;
  logic bank_idle_0;
  logic bank_idle_1;

  //====================================================================
  // Banks
  //====================================================================
  l2c_bank i_bank_0 (
    .forever_cpuclk  (forever_cpuclk),
    .cpurst_b        (cpurst_b),
    .req_vld         (req_vld_bank_0),
    .req_op          (req_op_bank_0),
    .req_addr        (req_addr_bank_0),
    .req_wdata       (req_wdata_bank_0),
    .tag_setup       (tag_setup),
    .tag_latency     (tag_latency),
    .data_setup      (data_setup),
    .data_latency    (data_latency),
    .bank_flush_req  (bank_flush_req),
    .credit_ret      (credit_ret_bank_0),
    .cmplt           (cmplt_bank_0),
    .resp            (resp_bank_0),
    .rdata           (rdata_bank_0),
    .bank_flush_done (bank_flush_done_0),
    .bank_idle       (bank_idle_0)
  );

  l2c_bank i_bank_1 (
    .forever_cpuclk  (forever_cpuclk),
    .cpurst_b        (cpurst_b),
    .req_vld         (req_vld_bank_1),
    .req_op          (req_op_bank_1),
    .req_addr        (req_addr_bank_1),
    .req_wdata       (req_wdata_bank_1),
    .tag_setup       (tag_setup),
    .tag_latency     (tag_latency),
    .data_setup      (data_setup),
    .data_latency    (data_latency),
    .bank_flush_req  (bank_flush_req),
    .credit_ret      (credit_ret_bank_1),
    .cmplt           (cmplt_bank_1),
    .resp            (resp_bank_1),
    .rdata           (rdata_bank_1),
    .bank_flush_done (bank_flush_done_1),
    .bank_idle       (bank_idle_1)
  );

  //====================================================================
  // SoC flush
  //====================================================================
  l2c_flush_ctrl i_flush_ctrl (
    .forever_cpuclk    (forever_cpuclk),
    .cpurst_b          (cpurst_b),
    .flush_req         (flush_req),
    .ciu_no_op         (ciu_no_op),
    .bank_flush_done_0 (bank_flush_done_0),
    .bank_flush_done_1 (bank_flush_done_1),
    .bank_flush_req    (bank_flush_req),
    .flush_done        (flush_done),
    .flush_idle        (flush_idle)
  );

  // Slice is quiet only when both banks are
  assign no_op = bank_idle_0 & bank_idle_1;

endmodule

// File: tb_clk_gen.sv
//====================================================================
// Testbench clock and reset
// 20 ns clock and a reset held low for the first two cycles
//====================================================================

module tb_clk_gen (
  output logic forever_cpuclk,
  output logic cpurst_b
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #10 forever_cpuclk = ~forever_cpuclk;
    end
  end

  initial begin
    cpurst_b = 1'b0;
    repeat (2) @(posedge forever_cpuclk);
    #2 cpurst_b = 1'b1;
  end

endmodule

// File: tb_l2c_top.sv
//====================================================================
// L2 cache slice testbench
// Credit-gated requests on both banks, a line model per bank and
// response, latency, credit and flush checks
//====================================================================

module tb_l2c_top import l2c_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned WAIT_LIMIT = 200;
  localparam int unsigned EXP_W = L2C_DATA_W + 2;
  // Access settings as {tag_setup, tag_latency, data_setup, data_latency}
  localparam logic [7:0] LAT_CFG [5] = '{8'h00, 8'hA3, 8'hFF, 8'h3D, 8'hE2};

  logic                  forever_cpuclk;
  logic                  cpurst_b;
  logic                  req_vld_bank_0;
  l2c_op_e               req_op_bank_0;
  logic [L2C_ADDR_W-1:0] req_addr_bank_0;
  logic [L2C_DATA_W-1:0] req_wdata_bank_0;
  logic                  req_vld_bank_1;
  l2c_op_e               req_op_bank_1;
  logic [L2C_ADDR_W-1:0] req_addr_bank_1;
  logic [L2C_DATA_W-1:0] req_wdata_bank_1;
  logic                  tag_setup;
  logic [2:0]            tag_latency;
  logic                  data_setup;
  logic [2:0]            data_latency;
  logic                  flush_req;
  logic                  ciu_no_op;
  logic                  credit_ret_bank_0;
  logic                  cmplt_bank_0;
  l2c_resp_e             resp_bank_0;
  logic [L2C_DATA_W-1:0] rdata_bank_0;
  logic                  credit_ret_bank_1;
  logic                  cmplt_bank_1;
  l2c_resp_e             resp_bank_1;
  logic [L2C_DATA_W-1:0] rdata_bank_1;
  logic                  flush_done;
  logic                  flush_idle;
  logic                  no_op;

  // Reference model
  logic [EXP_W-1:0]      exp_q0 [$];
  logic [EXP_W-1:0]      exp_q1 [$];
  logic [EXP_W-1:0]      exp_head [2];
  logic                  exp_vld [2];
  logic                  cm_seen [2];
  int                    credits [2] = '{2, 2};
  int                    ret_count [2] = '{0, 0};
  logic                  m_valid [2][L2C_SETS];
  logic [L2C_TAG_W-1:0]  m_tag [2][L2C_SETS];
  logic [L2C_DATA_W-1:0] m_data [2][L2C_SETS];
  logic [L2C_ADDR_W:0]   written_q [$];
  logic [31:0]           seed;
  int                    errors = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  int                    err_mark = 0;

  tb_clk_gen i_clk_gen (
    .forever_cpuclk (forever_cpuclk),
    .cpurst_b       (cpurst_b)
  );

  l2c_top i_dut (.*);

  //====================================================================
  // Helpers
  //====================================================================
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Clamped tag plus data cycles, never below one
  function automatic int acc_cycles(int ts, int tl, int ds, int dl);
    int t_cyc;
    int d_cyc;
    t_cyc = (ts + tl > int'(L2C_TAG_CYC_MAX)) ? int'(L2C_TAG_CYC_MAX) : ts + tl;
    d_cyc = (ds + dl > int'(L2C_DATA_CYC_MAX)) ? int'(L2C_DATA_CYC_MAX) : ds + dl;
    return (t_cyc + d_cyc == 0) ? 1 : t_cyc + d_cyc;
  endfunction

  function automatic void refresh_heads();
    exp_vld[0]  = (exp_q0.size() != 0);
    exp_vld[1]  = (exp_q1.size() != 0);
    exp_head[0] = exp_vld[0] ? exp_q0[0] : '0;
    exp_head[1] = exp_vld[1] ? exp_q1[0] : '0;
  endfunction

  function automatic logic slice_quiet();
    return no_op && (exp_q0.size() == 0) && (exp_q1.size() == 0) &&
           (credits[0] == L2C_REQ_CREDITS) && (credits[1] == L2C_REQ_CREDITS);
  endfunction

  task automatic finish_run();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic timeout_fail(string what);
    errors++;
    $display("TIMEOUT: gave up waiting for %s", what);
    finish_run();
  endtask

  task automatic expect_val(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "failed");
    err_mark = errors;
  endtask

  // The bank serves requests in order, so the model decides at issue time
  task automatic drive_req(int bank, l2c_op_e op, logic [L2C_ADDR_W-1:0] addr,
                           logic [L2C_DATA_W-1:0] wdata);
    logic [L2C_INDEX_W-1:0] idx;
    logic [L2C_TAG_W-1:0]   tag;
    logic [EXP_W-1:0]       entry;
    idx = addr[L2C_INDEX_W-1:0];
    tag = addr[L2C_ADDR_W-1:L2C_INDEX_W];
    if (op == L2C_OP_WRITE) begin
      entry = {L2C_RESP_WACK, {L2C_DATA_W{1'b0}}};
      m_valid[bank][idx] = 1'b1;
      m_tag[bank][idx]   = tag;
      m_data[bank][idx]  = wdata;
      written_q.push_back({bank[0], addr});
    end else if (m_valid[bank][idx] && (m_tag[bank][idx] == tag)) begin
      entry = {L2C_RESP_HIT, m_data[bank][idx]};
    end else begin
      entry = {L2C_RESP_MISS, {L2C_DATA_W{1'b0}}};
    end
    credits[bank]--;
    if (bank == 0) begin
      exp_q0.push_back(entry);
      req_vld_bank_0   = 1'b1;
      req_op_bank_0    = op;
      req_addr_bank_0  = addr;
      req_wdata_bank_0 = wdata;
    end else begin
      exp_q1.push_back(entry);
      req_vld_bank_1   = 1'b1;
      req_op_bank_1    = op;
      req_addr_bank_1  = addr;
      req_wdata_bank_1 = wdata;
    end
    refresh_heads();
  endtask

  task automatic wait_credit(int bank);
    int n;
    n = 0;
    while ((credits[bank] == 0) && (n < WAIT_LIMIT)) begin
      @(negedge forever_cpuclk);
      n++;
    end
    if (credits[bank] == 0) begin
      timeout_fail("a returned credit");
    end
  endtask

  // One-cycle request pulse
  task automatic issue(int bank, l2c_op_e op, logic [L2C_ADDR_W-1:0] addr,
                       logic [L2C_DATA_W-1:0] wdata);
    wait_credit(bank);
    @(posedge forever_cpuclk);
    #2;
    drive_req(bank, op, addr, wdata);
    @(posedge forever_cpuclk);
    #2;
    req_vld_bank_0 = 1'b0;
    req_vld_bank_1 = 1'b0;
  endtask

  task automatic wait_quiet();
    int n;
    n = 0;
    @(negedge forever_cpuclk);
    while (!slice_quiet() && (n < WAIT_LIMIT)) begin
      @(negedge forever_cpuclk);
      n++;
    end
    if (!slice_quiet()) begin
      timeout_fail("all responses and credits");
    end
  endtask

  task automatic check_latency(logic [7:0] cfg);
    int n;
    int exp_n;
    @(posedge forever_cpuclk);
    #2;
    {tag_setup, tag_latency, data_setup, data_latency} = cfg;
    exp_n = acc_cycles(cfg[7], cfg[6:4], cfg[3], cfg[2:0]);
    issue(1, L2C_OP_READ, L2C_ADDR_W'(next_rand()), '0);
    // Count falling edges from the sampling edge up to the completion
    n = 0;
    @(negedge forever_cpuclk);
    while (!cmplt_bank_1 && (n < WAIT_LIMIT)) begin
      n++;
      @(negedge forever_cpuclk);
    end
    if (!cmplt_bank_1) begin
      timeout_fail("cmplt_bank_1");
    end else begin
      expect_val("cmplt_bank_1 latency", 64'(n), 64'(exp_n + 1));
      wait_quiet();
    end
  endtask

  //====================================================================
  // Monitors and assertions
  //====================================================================
  always @(negedge forever_cpuclk) begin
    cm_seen[0] = cmplt_bank_0;
    cm_seen[1] = cmplt_bank_1;
    if (credit_ret_bank_0) begin
      credits[0]++;
      ret_count[0]++;
    end
    if (credit_ret_bank_1) begin
      credits[1]++;
      ret_count[1]++;
    end
  end

  // Retire the expected response after the edge that sampled it
  always @(posedge forever_cpuclk) begin
    if (cm_seen[0] && (exp_q0.size() != 0)) begin
      void'(exp_q0.pop_front());
    end
    if (cm_seen[1] && (exp_q1.size() != 0)) begin
      void'(exp_q1.pop_front());
    end
    refresh_heads();
  end

  resp_ok_0: assert property (@(posedge forever_cpuclk) disable iff (!cpurst_b)
      cmplt_bank_0 |-> ({resp_bank_0, rdata_bank_0} == exp_head[0]))
    else begin
      errors++;
      $display("CHECK FAILED resp_bank_0/rdata_bank_0: got 0x%0h expected 0x%0h",
               $sampled({resp_bank_0, rdata_bank_0}), $sampled(exp_head[0]));
    end

  resp_ok_1: assert property (@(posedge forever_cpuclk) disable iff (!cpurst_b)
      cmplt_bank_1 |-> ({resp_bank_1, rdata_bank_1} == exp_head[1]))
    else begin
      errors++;
      $display("CHECK FAILED resp_bank_1/rdata_bank_1: got 0x%0h expected 0x%0h",
               $sampled({resp_bank_1, rdata_bank_1}), $sampled(exp_head[1]));
    end

  cmplt_expected: assert property (@(posedge forever_cpuclk) disable iff (!cpurst_b)
      !(cmplt_bank_0 && !exp_vld[0]) && !(cmplt_bank_1 && !exp_vld[1]))
    else begin
      errors++;
      $display("A bank completed a request that was never sent");
    end

  // A bank is still timing its access in the cycle before it completes
  no_op_busy: assert property (@(posedge forever_cpuclk) disable iff (!cpurst_b)
      (cmplt_bank_0 || cmplt_bank_1) |-> !$past(no_op))
    else begin
      errors++;
      $display("CHECK FAILED no_op: got 0x1 expected 0x0 while a bank is busy");
    end

  credit_range: assert property (@(posedge forever_cpuclk)
      (credits[0] >= 0) && (credits[0] <= int'(L2C_REQ_CREDITS)) &&
      (credits[1] >= 0) && (credits[1] <= int'(L2C_REQ_CREDITS)))
    else begin
      errors++;
      $display("CHECK FAILED credits: bank_0 0x%0h bank_1 0x%0h allowed 0x0 to 0x%0h",
               $sampled(credits[0]), $sampled(credits[1]), L2C_REQ_CREDITS);
    end

  flush_held_off: assert property (@(posedge forever_cpuclk) disable iff (!cpurst_b)
      (flush_idle && !ciu_no_op) |=> flush_idle)
    else begin
      errors++;
      $display("CHECK FAILED flush_idle: got 0x0 expected 0x1 while ciu_no_op is low");
    end

  //====================================================================
  // Stimulus
  //====================================================================
  initial begin
    int                    n;
    int                    ret_mark [2];
    logic [L2C_ADDR_W-1:0] addr;
    logic [L2C_DATA_W-1:0] data;
    logic [L2C_ADDR_W-1:0] pair_addr [2];
    req_vld_bank_0   = 1'b0;
    req_op_bank_0    = L2C_OP_READ;
    req_addr_bank_0  = '0;
    req_wdata_bank_0 = '0;
    req_vld_bank_1   = 1'b0;
    req_op_bank_1    = L2C_OP_READ;
    req_addr_bank_1  = '0;
    req_wdata_bank_1 = '0;
    {tag_setup, tag_latency, data_setup, data_latency} = 8'h92;
    flush_req = 1'b0;
    ciu_no_op = 1'b0;
    seed      = 32'ha1c9c6d9;
    cm_seen   = '{1'b0, 1'b0};
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < L2C_SETS; i++) begin
        m_valid[b][i] = 1'b0;
      end
    end
    refresh_heads();

    n = 0;
    while ((cpurst_b !== 1'b1) && (n < 20)) begin
      @(negedge forever_cpuclk);
      n++;
    end
    if (cpurst_b !== 1'b1) begin
      timeout_fail("reset release");
    end

    // Test 1
    @(negedge forever_cpuclk);
    expect_val("no_op", no_op, 1);
    expect_val("flush_idle", flush_idle, 1);
    expect_val("flush_done", flush_done, 0);
    expect_val("cmplt_bank_0", cmplt_bank_0, 0);
    expect_val("cmplt_bank_1", cmplt_bank_1, 0);
    expect_val("credit_ret_bank_0", credit_ret_bank_0, 0);
    expect_val("credit_ret_bank_1", credit_ret_bank_1, 0);
    end_test("reset values");

    // Test 2 ends with a read of the same index under another tag
    addr = L2C_ADDR_W'(next_rand());
    data = {next_rand(), next_rand()};
    issue(0, L2C_OP_WRITE, addr, data);
    issue(0, L2C_OP_READ, addr, '0);
    issue(0, L2C_OP_READ, addr ^ L2C_ADDR_W'(16'h0010), '0);
    wait_quiet();
    end_test("write then read");

    // Test 3
    foreach (LAT_CFG[k]) begin
      check_latency(LAT_CFG[k]);
    end
    end_test("exact latency");

    // Test 4
    ret_mark[0] = ret_count[0];
    ret_mark[1] = ret_count[1];
    pair_addr[0] = L2C_ADDR_W'(next_rand());
    pair_addr[1] = L2C_ADDR_W'(next_rand());
    wait_credit(0);
    wait_credit(1);
    @(posedge forever_cpuclk);
    #2;
    drive_req(0, L2C_OP_WRITE, pair_addr[0], {next_rand(), next_rand()});
    drive_req(1, L2C_OP_WRITE, pair_addr[1], {next_rand(), next_rand()});
    @(posedge forever_cpuclk);
    #2;
    drive_req(0, L2C_OP_READ, pair_addr[0], '0);
    drive_req(1, L2C_OP_READ, pair_addr[1], '0);
    @(posedge forever_cpuclk);
    #2;
    req_vld_bank_0 = 1'b0;
    req_vld_bank_1 = 1'b0;
    wait_quiet();
    expect_val("credit_ret_bank_0 pulses", 64'(ret_count[0] - ret_mark[0]), 2);
    expect_val("credit_ret_bank_1 pulses", 64'(ret_count[1] - ret_mark[1]), 2);
    end_test("credits and order");

    // Test 5
    @(posedge forever_cpuclk);
    #2;
    flush_req = 1'b1;
    ciu_no_op = 1'b0;
    repeat (8) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    expect_val("flush_idle", flush_idle, 1);
    @(posedge forever_cpuclk);
    #2;
    ciu_no_op = 1'b1;
    n = 0;
    while (!flush_done && (n < WAIT_LIMIT)) begin
      @(negedge forever_cpuclk);
      n++;
    end
    if (!flush_done) begin
      timeout_fail("flush_done");
    end
    @(posedge forever_cpuclk);
    #2;
    flush_req = 1'b0;
    n = 0;
    @(negedge forever_cpuclk);
    while (!flush_idle && (n < WAIT_LIMIT)) begin
      @(negedge forever_cpuclk);
      n++;
    end
    if (!flush_idle) begin
      timeout_fail("flush_idle after the flush");
    end
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < L2C_SETS; i++) begin
        m_valid[b][i] = 1'b0;
      end
    end
    foreach (written_q[i]) begin
      issue(int'(written_q[i][L2C_ADDR_W]), L2C_OP_READ, written_q[i][L2C_ADDR_W-1:0], '0);
    end
    wait_quiet();
    end_test("flush");

    finish_run();
  end

endmodule
